/* flist.f */
+incdir+include
source/parser_pkg.sv
source/header_capture.sv
source/header_queue.sv
source/parse_action_ram.sv
source/phv_extract.sv
source/parser_top.sv
verif/parser_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module parser_tb \
	-o parser_tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/parser_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* source/header_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module header_capture
	import parser_pkg::*;
#(
	parameter int HDR_QUEUE_DEPTH = 4
) (
	input  wire                    axis_clk,
	input  wire                    aresetn,
	input  wire [DATA_WIDTH-1:0]   s_axis_tdata,
	input  wire                    s_axis_tvalid,
	input  wire                    s_axis_tlast,
	input  wire                    credit_return,
	output logic                   hdr_push,
	output logic [HDR_WIDTH-1:0]   hdr_data,
	output logic [15:0]            drop_count
);

	localparam int SEG_CNT_WIDTH = $clog2(SEG_NUM + 1);

	logic                      in_pkt;
	logic [SEG_CNT_WIDTH-1:0]  seg_cnt;
	logic [SEG_CNT_WIDTH-1:0]  seg_idx;
	logic                      seg_write;
	logic                      hdr_done;
	logic                      push_now;
	logic [CREDIT_WIDTH-1:0]   credit_cnt;

	// a beat outside a packet always lands in the top segment
	assign seg_idx   = in_pkt ? seg_cnt : '0;
	assign seg_write = s_axis_tvalid && (seg_idx < SEG_CNT_WIDTH'(SEG_NUM));
	assign hdr_done  = seg_write && (s_axis_tlast || seg_idx == SEG_CNT_WIDTH'(SEG_NUM - 1));
	assign push_now  = hdr_done && (credit_cnt != '0);

	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			in_pkt  <= 1'b0;
			seg_cnt <= '0;
		end else if (s_axis_tvalid) begin
			in_pkt <= !s_axis_tlast;
			// past the last segment the count parks until tlast
			if (seg_write)
				seg_cnt <= seg_idx + 1'b1;
		end
	end

	// first beat clears the lower segments so short packets are zero filled
	always_ff @(posedge axis_clk) begin
		if (seg_write) begin
			if (seg_idx == '0)
				hdr_data <= {s_axis_tdata, {(HDR_WIDTH - DATA_WIDTH){1'b0}}};
			else
				hdr_data[HDR_WIDTH-1-seg_idx*DATA_WIDTH -: DATA_WIDTH] <= s_axis_tdata;
		end
	end

	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			hdr_push   <= 1'b0;
			credit_cnt <= CREDIT_WIDTH'(HDR_QUEUE_DEPTH);
			drop_count <= '0;
		end else begin
			hdr_push   <= push_now;
			credit_cnt <= credit_cnt - CREDIT_WIDTH'(push_now) + CREDIT_WIDTH'(credit_return);
			if (hdr_done && !push_now)
				drop_count <= drop_count + 16'd1;
		end
	end

	// queue returns at most what was spent
	credit_bound: assert property (@(posedge axis_clk) disable iff (!aresetn)
		credit_cnt <= CREDIT_WIDTH'(HDR_QUEUE_DEPTH));

endmodule

`default_nettype wire

/* source/header_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module header_queue
	import parser_pkg::*;
#(
	parameter int HDR_QUEUE_DEPTH = 4
) (
	input  wire                    axis_clk,
	input  wire                    aresetn,
	input  wire                    hdr_push,
	input  wire [HDR_WIDTH-1:0]    hdr_data,
	input  wire                    hdr_pop,
	output logic                   hdr_avail,
	output logic [HDR_WIDTH-1:0]   hdr_head,
	output logic                   credit_return
);

	localparam int PTR_WIDTH = (HDR_QUEUE_DEPTH > 1) ? $clog2(HDR_QUEUE_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(HDR_QUEUE_DEPTH + 1);

	logic [HDR_WIDTH-1:0]  mem [HDR_QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0]  wr_ptr;
	logic [PTR_WIDTH-1:0]  rd_ptr;
	logic [CNT_WIDTH-1:0]  count;

	assign hdr_avail = count != '0;
	assign hdr_head  = mem[rd_ptr];

	always_ff @(posedge axis_clk) begin
		if (hdr_push)
			mem[wr_ptr] <= hdr_data;
	end

	// pointers wrap by compare since the depth need not be a power of two
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (hdr_push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(HDR_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (hdr_pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(HDR_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count         <= count + CNT_WIDTH'(hdr_push) - CNT_WIDTH'(hdr_pop);
			credit_return <= hdr_pop;
		end
	end

	// the producer's credits must keep it from overrunning us
	no_push_full: assert property (@(posedge axis_clk) disable iff (!aresetn)
		hdr_push |-> count < CNT_WIDTH'(HDR_QUEUE_DEPTH));

	no_pop_empty: assert property (@(posedge axis_clk) disable iff (!aresetn)
		hdr_pop |-> hdr_avail);

endmodule

`default_nettype wire

/* source/parse_action_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module parse_action_ram
	import parser_pkg::*;
(
	input  wire                        axis_clk,
	input  wire                        wr_en,
	input  wire [ACT_ADDR_WIDTH-1:0]   wr_addr,
	input  wire [ACT_WIDTH-1:0]        wr_data,
	input  wire [ACT_ADDR_WIDTH-1:0]   rd_addr,
	output logic [ACT_WIDTH-1:0]       rd_data
);

	localparam int DEPTH = 2 ** ACT_ADDR_WIDTH;

	logic [ACT_WIDTH-1:0] mem [DEPTH];

	// simple dual port, read returns old data on a same-address write
	always_ff @(posedge axis_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge axis_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* source/parser_pkg.sv */
`default_nettype none

package parser_pkg;

	// stream and header geometry
	localparam int DATA_WIDTH = 256;
	localparam int HDR_WIDTH  = 1024;
	localparam int SEG_NUM    = HDR_WIDTH / DATA_WIDTH;

	// PHV containers, eight of each size
	localparam int NUM_CONT      = 8;
	localparam int CONT_2B_WIDTH = 16;
	localparam int CONT_4B_WIDTH = 32;
	localparam int CONT_6B_WIDTH = 48;
	localparam int COND_WIDTH    = 20;
	localparam int NUM_COND_ACT  = 5;
	localparam int META_WIDTH    = 256;
	localparam int PHV_WIDTH     = NUM_CONT * (CONT_6B_WIDTH + CONT_4B_WIDTH + CONT_2B_WIDTH)
		+ NUM_COND_ACT * COND_WIDTH + META_WIDTH;

	// action table
	localparam int ACT_WIDTH      = 260;
	localparam int ACT_ADDR_WIDTH = 4;
	localparam int NUM_PARSE_ACT  = 10;

	// VLAN ID sits 116 bits below the top of the header
	localparam int VLAN_WIDTH   = 12;
	localparam int VLAN_MSB     = HDR_WIDTH - 1 - 116;
	localparam int VLAN_IDX_LSB = 4;

	localparam int CREDIT_WIDTH = 3;

	// one parse action word, action 0 at bit 244 and the rest 16 bits apart below it
	localparam int PA_WIDTH      = 16;
	localparam int PA0_LSB       = 244;
	localparam int PA_VALID_BIT  = 0;
	localparam int PA_CIDX_LSB   = 1;
	localparam int PA_CIDX_WIDTH = 3;
	localparam int PA_SIZE_LSB   = 4;
	localparam int PA_SIZE_WIDTH = 2;
	localparam int PA_OFF_LSB    = 6;
	localparam int PA_OFF_WIDTH  = 7;

	// size codes, 0 means no extraction
	localparam logic [PA_SIZE_WIDTH-1:0] SIZE_2B = 2'd1;
	localparam logic [PA_SIZE_WIDTH-1:0] SIZE_4B = 2'd2;
	localparam logic [PA_SIZE_WIDTH-1:0] SIZE_6B = 2'd3;

endpackage

`default_nettype wire

/* source/parser_top.sv */
`timescale 1ns/100ps
`default_nettype none

module parser_top
	import parser_pkg::*;
#(
	parameter int HDR_QUEUE_DEPTH = 4,
	parameter int PHV_CREDITS     = 2
) (
	input  wire                        axis_clk,
	input  wire                        aresetn,
	input  wire [DATA_WIDTH-1:0]       s_axis_tdata,
	input  wire                        s_axis_tvalid,
	input  wire                        s_axis_tlast,
	input  wire                        cfg_wr_en,
	input  wire [ACT_ADDR_WIDTH-1:0]   cfg_addr,
	input  wire [ACT_WIDTH-1:0]        cfg_data,
	input  wire                        phv_credit,
	output wire                        phv_valid,
	output wire [PHV_WIDTH-1:0]        phv_out,
	output wire [15:0]                 drop_count
);

	wire                   hdr_push;
	wire [HDR_WIDTH-1:0]   hdr_data;
	wire                   credit_return;
	wire                   hdr_avail;
	wire [HDR_WIDTH-1:0]   hdr_head;
	wire                   hdr_pop;

	header_capture #(
		.HDR_QUEUE_DEPTH (HDR_QUEUE_DEPTH)
	) capture_i (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.credit_return (credit_return),
		.hdr_push      (hdr_push),
		.hdr_data      (hdr_data),
		.drop_count    (drop_count)
	);

	header_queue #(
		.HDR_QUEUE_DEPTH (HDR_QUEUE_DEPTH)
	) queue_i (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.hdr_push      (hdr_push),
		.hdr_data      (hdr_data),
		.hdr_pop       (hdr_pop),
		.hdr_avail     (hdr_avail),
		.hdr_head      (hdr_head),
		.credit_return (credit_return)
	);

	phv_extract #(
		.PHV_CREDITS (PHV_CREDITS)
	) extract_i (
		.axis_clk   (axis_clk),
		.aresetn    (aresetn),
		.hdr_avail  (hdr_avail),
		.hdr_head   (hdr_head),
		.phv_credit (phv_credit),
		.cfg_wr_en  (cfg_wr_en),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.hdr_pop    (hdr_pop),
		.phv_valid  (phv_valid),
		.phv_out    (phv_out)
	);

endmodule

`default_nettype wire

/* source/phv_extract.sv */
`timescale 1ns/100ps
`default_nettype none

module phv_extract
	import parser_pkg::*;
#(
	parameter int PHV_CREDITS = 2
) (
	input  wire                        axis_clk,
	input  wire                        aresetn,
	input  wire                        hdr_avail,
	input  wire [HDR_WIDTH-1:0]        hdr_head,
	input  wire                        phv_credit,
	input  wire                        cfg_wr_en,
	input  wire [ACT_ADDR_WIDTH-1:0]   cfg_addr,
	input  wire [ACT_WIDTH-1:0]        cfg_data,
	output logic                       hdr_pop,
	output logic                       phv_valid,
	output logic [PHV_WIDTH-1:0]       phv_out
);

	logic [VLAN_WIDTH-1:0]      vlan_id;
	logic [ACT_ADDR_WIDTH-1:0]  act_addr;
	logic [ACT_WIDTH-1:0]       act_entry;
	logic [CREDIT_WIDTH-1:0]    credit_cnt;
	logic                       s1_valid;
	logic [HDR_WIDTH-1:0]       s1_hdr;

	logic [NUM_PARSE_ACT-1:0][PA_WIDTH-1:0]       parse_act;
	logic [CONT_6B_WIDTH-1:0]                     field [NUM_PARSE_ACT];
	// ascending range puts condition 0 at the top of the PHV
	logic [0:NUM_COND_ACT-1][COND_WIDTH-1:0]      cond_act;
	logic [NUM_CONT-1:0][CONT_6B_WIDTH-1:0]       val_6b;
	logic [NUM_CONT-1:0][CONT_4B_WIDTH-1:0]       val_4b;
	logic [NUM_CONT-1:0][CONT_2B_WIDTH-1:0]       val_2b;

	assign vlan_id  = hdr_head[VLAN_MSB -: VLAN_WIDTH];
	assign act_addr = vlan_id[VLAN_IDX_LSB +: ACT_ADDR_WIDTH];

	// the header in stage 1 already owns a credit, so leave it out
	assign hdr_pop = hdr_avail && (credit_cnt > CREDIT_WIDTH'(s1_valid));

	parse_action_ram act_ram_i (
		.axis_clk (axis_clk),
		.wr_en    (cfg_wr_en),
		.wr_addr  (cfg_addr),
		.wr_data  (cfg_data),
		.rd_addr  (act_addr),
		.rd_data  (act_entry)
	);

	always_ff @(posedge axis_clk) begin
		if (hdr_pop)
			s1_hdr <= hdr_head;
	end

	for (genvar k = 0; k < NUM_PARSE_ACT; k++) begin : g_act
		assign parse_act[k] = act_entry[PA0_LSB - PA_WIDTH*k +: PA_WIDTH];
		// offset counts bytes up from the header LSB, bits past the top read as zero
		assign field[k] = CONT_6B_WIDTH'(s1_hdr >> {parse_act[k][PA_OFF_LSB +: PA_OFF_WIDTH], 3'b000});
	end

	for (genvar j = 0; j < NUM_COND_ACT; j++) begin : g_cond
		assign cond_act[j] = act_entry[COND_WIDTH*j +: COND_WIDTH];
	end

	// later actions win on a shared container
	always_comb begin
		val_6b = '0;
		val_4b = '0;
		val_2b = '0;
		for (int k = 0; k < NUM_PARSE_ACT; k++) begin
			if (parse_act[k][PA_VALID_BIT]) begin
				case (parse_act[k][PA_SIZE_LSB +: PA_SIZE_WIDTH])
					SIZE_2B: val_2b[parse_act[k][PA_CIDX_LSB +: PA_CIDX_WIDTH]] =
						field[k][CONT_2B_WIDTH-1:0];
					SIZE_4B: val_4b[parse_act[k][PA_CIDX_LSB +: PA_CIDX_WIDTH]] =
						field[k][CONT_4B_WIDTH-1:0];
					SIZE_6B: val_6b[parse_act[k][PA_CIDX_LSB +: PA_CIDX_WIDTH]] = field[k];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge axis_clk) begin
		if (s1_valid)
			phv_out <= {val_6b, val_4b, val_2b, cond_act, {META_WIDTH{1'b0}}};
	end

	// the credit is taken on the edge that raises phv_valid
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			s1_valid   <= 1'b0;
			phv_valid  <= 1'b0;
			credit_cnt <= CREDIT_WIDTH'(PHV_CREDITS);
		end else begin
			s1_valid   <= hdr_pop;
			phv_valid  <= s1_valid;
			credit_cnt <= credit_cnt - CREDIT_WIDTH'(s1_valid) + CREDIT_WIDTH'(phv_credit);
		end
	end

	// downstream never hands back more than it was given
	credit_bound: assert property (@(posedge axis_clk) disable iff (!aresetn)
		credit_cnt <= CREDIT_WIDTH'(PHV_CREDITS));

endmodule

`default_nettype wire

/* include/parser_tb_ref.svh */
`ifndef PARSER_TB_REF_SVH
`define PARSER_TB_REF_SVH

// model of the extractor using parser_pkg from the including module
// containers go into the PHV from the top bit downwards
function automatic logic [PHV_WIDTH-1:0] expected_phv(
	input logic [HDR_WIDTH-1:0] hdr,
	input logic [ACT_WIDTH-1:0] act_table [2**ACT_ADDR_WIDTH]
);
	logic [VLAN_WIDTH-1:0]     vlan;
	logic [ACT_WIDTH-1:0]      entry;
	logic [PA_WIDTH-1:0]       act;
	logic [HDR_WIDTH-1:0]      shifted;
	logic [CONT_6B_WIDTH-1:0]  c6 [NUM_CONT];
	logic [CONT_4B_WIDTH-1:0]  c4 [NUM_CONT];
	logic [CONT_2B_WIDTH-1:0]  c2 [NUM_CONT];
	logic [PHV_WIDTH-1:0]      phv;
	int                        pos;

	vlan  = hdr[VLAN_MSB -: VLAN_WIDTH];
	entry = act_table[vlan[VLAN_IDX_LSB +: ACT_ADDR_WIDTH]];
	for (int c = 0; c < NUM_CONT; c++) begin
		c6[c] = '0;
		c4[c] = '0;
		c2[c] = '0;
	end

	for (int k = 0; k < NUM_PARSE_ACT; k++) begin
		act = entry[PA0_LSB - PA_WIDTH*k +: PA_WIDTH];
		if (act[PA_VALID_BIT]) begin
			shifted = hdr >> (8 * act[PA_OFF_LSB +: PA_OFF_WIDTH]);
			case (act[PA_SIZE_LSB +: PA_SIZE_WIDTH])
				SIZE_2B: c2[act[PA_CIDX_LSB +: PA_CIDX_WIDTH]] = shifted[CONT_2B_WIDTH-1:0];
				SIZE_4B: c4[act[PA_CIDX_LSB +: PA_CIDX_WIDTH]] = shifted[CONT_4B_WIDTH-1:0];
				SIZE_6B: c6[act[PA_CIDX_LSB +: PA_CIDX_WIDTH]] = shifted[CONT_6B_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// metadata at the bottom is left at zero
	phv = '0;
	pos = PHV_WIDTH;
	for (int c = NUM_CONT - 1; c >= 0; c--) begin
		pos -= CONT_6B_WIDTH;
		phv[pos +: CONT_6B_WIDTH] = c6[c];
	end
	for (int c = NUM_CONT - 1; c >= 0; c--) begin
		pos -= CONT_4B_WIDTH;
		phv[pos +: CONT_4B_WIDTH] = c4[c];
	end
	for (int c = NUM_CONT - 1; c >= 0; c--) begin
		pos -= CONT_2B_WIDTH;
		phv[pos +: CONT_2B_WIDTH] = c2[c];
	end
	for (int j = 0; j < NUM_COND_ACT; j++) begin
		pos -= COND_WIDTH;
		phv[pos +: COND_WIDTH] = entry[COND_WIDTH*j +: COND_WIDTH];
	end
	return phv;
endfunction

`endif

/* verif/parser_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module parser_tb
	import parser_pkg::*;
();

	localparam int HDR_QUEUE_DEPTH = 4;
	localparam int PHV_CREDITS     = 2;
	localparam int SEED            = 49801;
	localparam int DRAIN_LIMIT     = 50;
	// beat bit that carries VLAN ID bit 4 in the first beat
	localparam int IDX_BEAT_BIT    = VLAN_MSB - VLAN_WIDTH + 1 + VLAN_IDX_LSB
		- (HDR_WIDTH - DATA_WIDTH);
	// budget per test in cycles, reset first
	localparam int RUN_CYCLES      = 10 + 100 + 60 + 80 + 180 + 120 + 60;
	localparam int WATCHDOG_NS     = RUN_CYCLES * 8 * 2;

	logic                       axis_clk;
	logic                       aresetn;
	logic [DATA_WIDTH-1:0]      s_axis_tdata;
	logic                       s_axis_tvalid;
	logic                       s_axis_tlast;
	logic                       cfg_wr_en;
	logic [ACT_ADDR_WIDTH-1:0]  cfg_addr;
	logic [ACT_WIDTH-1:0]       cfg_data;
	logic                       phv_credit;
	wire                        phv_valid;
	wire  [PHV_WIDTH-1:0]       phv_out;
	wire  [15:0]                drop_count;

	logic [ACT_WIDTH-1:0]       act_table [2**ACT_ADDR_WIDTH];
	logic [PHV_WIDTH-1:0]       exp_q [$];
	logic                       credit_en;
	int                         cycle = 0;
	int                         beat_cycle = 0;
	int                         last_valid_cycle = 0;
	int                         credits_owed = 0;
	int                         credits_given = 0;
	int                         rx_count = 0;
	int                         err_count = 0;
	int                         check_count = 0;
	int                         test_err_base = 0;

	`include "parser_tb_ref.svh"

	parser_top #(
		.HDR_QUEUE_DEPTH (HDR_QUEUE_DEPTH),
		.PHV_CREDITS     (PHV_CREDITS)
	) dut_i (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.cfg_wr_en     (cfg_wr_en),
		.cfg_addr      (cfg_addr),
		.cfg_data      (cfg_data),
		.phv_credit    (phv_credit),
		.phv_valid     (phv_valid),
		.phv_out       (phv_out),
		.drop_count    (drop_count)
	);

	initial begin
		axis_clk = 1'b0;
		forever #4 axis_clk = ~axis_clk;
	end

	initial begin
		forever begin
			@(posedge axis_clk);
			cycle++;
		end
	end

	task automatic check_val(input logic [PHV_WIDTH-1:0] got, input logic [PHV_WIDTH-1:0] exp,
		input string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [DATA_WIDTH-1:0] random_beat();
		logic [DATA_WIDTH-1:0] d;
		for (int w = 0; w < DATA_WIDTH / 32; w++)
			d[32*w +: 32] = $urandom;
		return d;
	endfunction

	// last action reuses the container of action 0
	function automatic logic [ACT_WIDTH-1:0] random_entry();
		logic [ACT_WIDTH-1:0] e;
		logic [PA_WIDTH-1:0]  a;
		logic [PA_WIDTH-1:0]  first;
		for (int j = 0; j < NUM_COND_ACT; j++)
			e[COND_WIDTH*j +: COND_WIDTH] = COND_WIDTH'($urandom);
		first = '0;
		for (int k = 0; k < NUM_PARSE_ACT; k++) begin
			a = PA_WIDTH'($urandom);
			a[PA_VALID_BIT] = ($urandom % 8) != 0;
			a[PA_SIZE_LSB +: PA_SIZE_WIDTH] = PA_SIZE_WIDTH'(1 + $urandom % 3);
			if (k == 0) begin
				a[PA_VALID_BIT] = 1'b1;
				first = a;
			end else if (k == NUM_PARSE_ACT - 1) begin
				a[PA_VALID_BIT] = 1'b1;
				a[PA_CIDX_LSB +: PA_CIDX_WIDTH] = first[PA_CIDX_LSB +: PA_CIDX_WIDTH];
				a[PA_SIZE_LSB +: PA_SIZE_WIDTH] = first[PA_SIZE_LSB +: PA_SIZE_WIDTH];
			end
			e[PA0_LSB - PA_WIDTH*k +: PA_WIDTH] = a;
		end
		return e;
	endfunction

	task automatic write_entry(input int idx, input logic [ACT_WIDTH-1:0] data);
		@(posedge axis_clk);
		#1;
		cfg_wr_en = 1'b1;
		cfg_addr  = idx[ACT_ADDR_WIDTH-1:0];
		cfg_data  = data;
		act_table[idx] = data;
		@(posedge axis_clk);
		#1;
		cfg_wr_en = 1'b0;
	endtask

	// table_idx below zero leaves the VLAN bits random
	task automatic send_packet(input int nbeats, input int table_idx, input bit accept);
		logic [HDR_WIDTH-1:0]  hdr;
		logic [DATA_WIDTH-1:0] beat;
		hdr = '0;
		for (int b = 0; b < nbeats; b++) begin
			beat = random_beat();
			if (b == 0 && table_idx >= 0)
				beat[IDX_BEAT_BIT +: ACT_ADDR_WIDTH] = ACT_ADDR_WIDTH'(table_idx);
			if (b < SEG_NUM)
				hdr[HDR_WIDTH-1-b*DATA_WIDTH -: DATA_WIDTH] = beat;
			@(posedge axis_clk);
			#1;
			s_axis_tdata  = beat;
			s_axis_tvalid = 1'b1;
			s_axis_tlast  = (b == nbeats - 1);
			beat_cycle    = cycle;
		end
		if (accept)
			exp_q.push_back(expected_phv(hdr, act_table));
		@(posedge axis_clk);
		#1;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || credits_owed != credits_given) && n < limit) begin
			@(negedge axis_clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected PHVs never arrived within %0d cycles", exp_q.size(), limit);
			err_count++;
			exp_q.delete();
		end
		repeat (3) @(negedge axis_clk);
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s, %0d errors", name,
			(err_count == test_err_base) ? "ok" : "failed", err_count - test_err_base);
		test_err_base = err_count;
	endtask

	// hands back one credit per cycle for each PHV seen
	initial begin
		phv_credit = 1'b0;
		forever begin
			@(posedge axis_clk);
			#1;
			if (credit_en && credits_owed != credits_given) begin
				phv_credit = 1'b1;
				credits_given++;
			end else begin
				phv_credit = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			@(negedge axis_clk);
			if (aresetn && phv_valid) begin
				rx_count++;
				credits_owed++;
				last_valid_cycle = cycle;
				if (exp_q.size() == 0) begin
					$display("unexpected PHV at %0t ns with no packet outstanding", $time);
					err_count++;
				end else begin
					check_val(phv_out, exp_q.pop_front(), "phv_out");
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int          idx;
		int          rx_before;
		logic [15:0] drop_before;
		void'($urandom(SEED));
		aresetn       = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		cfg_wr_en     = 1'b0;
		cfg_addr      = '0;
		cfg_data      = '0;
		credit_en     = 1'b1;
		repeat (2) @(posedge axis_clk);
		#1;
		aresetn = 1'b1;
		repeat (2) @(negedge axis_clk);
		check_val(PHV_WIDTH'(drop_count), '0, "drop_count after reset");
		check_val(PHV_WIDTH'(phv_valid), '0, "phv_valid after reset");

		for (int i = 0; i < 2**ACT_ADDR_WIDTH; i++)
			write_entry(i, random_entry());
		for (int i = 0; i < 8; i++)
			send_packet(4, -1, 1'b1);
		wait_drain(DRAIN_LIMIT);
		end_test("four-beat packets");

		for (int i = 0; i < 6; i++)
			send_packet(1 + i % 2, -1, 1'b1);
		wait_drain(DRAIN_LIMIT);
		end_test("short packets");

		for (int i = 0; i < 3; i++) begin
			send_packet(5 + i, -1, 1'b1);
			send_packet(4, -1, 1'b1);
		end
		wait_drain(DRAIN_LIMIT);
		end_test("long packets");

		for (int r = 0; r < 4; r++) begin
			idx = (r * 5 + 3) % 16;
			send_packet(4, idx, 1'b1);
			wait_drain(DRAIN_LIMIT);
			write_entry(idx, random_entry());
			send_packet(4, idx, 1'b1);
			wait_drain(DRAIN_LIMIT);
		end
		end_test("table select and rewrite");

		// two PHVs use the credits, the queue takes the next four, the rest drop
		credit_en   = 1'b0;
		rx_before   = rx_count;
		drop_before = drop_count;
		for (int i = 0; i < PHV_CREDITS + HDR_QUEUE_DEPTH + 2; i++)
			send_packet(4, -1, i < PHV_CREDITS + HDR_QUEUE_DEPTH);
		repeat (20) @(negedge axis_clk);
		check_val(PHV_WIDTH'(rx_count - rx_before), PHV_WIDTH'(PHV_CREDITS), "PHVs without credit");
		check_val(PHV_WIDTH'(drop_count), PHV_WIDTH'(drop_before + 16'd2), "drop_count");
		credit_en = 1'b1;
		wait_drain(DRAIN_LIMIT);
		end_test("back-pressure");

		for (int i = 0; i < 3; i++) begin
			send_packet((i == 0) ? 4 : i, -1, 1'b1);
			wait_drain(DRAIN_LIMIT);
			check_val(PHV_WIDTH'(last_valid_cycle - beat_cycle), PHV_WIDTH'(4), "latency");
		end
		end_test("latency");

		wait_drain(DRAIN_LIMIT);
		$display("summary: %0d checks, %0d errors, %0d PHVs received",
			check_count, err_count, rx_count);
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
